/* t05_huffman_lengths.f */
+incdir+.
t05_huffman_pkg.sv
t05_node_ram.sv
t05_node_table.sv
t05_scan_counter.sv
t05_controller.sv
t05_find_least.sv
t05_code_length.sv
t05_huffman_top.sv
t05_huffman_checker.sv
t05_huffman_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= t05_huffman_tb
FILELIST  ?= t05_huffman_lengths.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -e "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* t05_huffman_tb.sv */
`default_nettype none

`include "t05_huffman_macros.svh"

module t05_huffman_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 8;
  localparam int SYMW       = $clog2(`T05_NSYM);
  localparam int NUM_RUNS   = 12;
  // Worst case stream, 15 merges of one scan each, 16 walks
  localparam int RUN_CYCLES = `T05_MAXCHARS + 15 * 33 + 16 * 20;

  logic                       hwclk, rst_n, start, sym_valid, eof;
  logic [SYMW-1:0]            sym;
  logic                       len_valid, done, busy;
  logic [SYMW-1:0]            len_sym;
  t05_huffman_pkg::code_len_t len;
  int                         test_id, runs, errors;
  logic [15:0]                lfsr_q;

  t05_huffman_top t05_huffman_top_inst (
    .hwclk(hwclk), .rst_n_i(rst_n), .start_i(start), .sym_valid_i(sym_valid),
    .sym_i(sym), .eof_i(eof), .len_valid_o(len_valid), .len_sym_o(len_sym),
    .len_o(len), .done_o(done), .busy_o(busy)
  );

  t05_huffman_checker checker_inst (
    .hwclk(hwclk), .rst_n_i(rst_n), .test_id_i(test_id), .start_i(start),
    .sym_valid_i(sym_valid), .sym_i(sym), .eof_i(eof), .len_valid_i(len_valid),
    .len_sym_i(len_sym), .len_i(len), .done_i(done), .busy_i(busy), .runs_o(runs),
    .errors_o(errors)
  );

  initial begin
    hwclk = 1'b0;
    forever #(CLK_PERIOD / 2) hwclk = ~hwclk;
  end

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val    = (val << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic drive_inputs(input logic st, input logic vld, input int s, input logic ef);
    @(negedge hwclk);
    start     = st;
    sym_valid = vld;
    sym       = SYMW'(s);
    eof       = ef;
  endtask

  task automatic send_symbol(input int s);
    drive_inputs(1'b0, 1'b1, s, 1'b0);
  endtask

  task automatic start_build(input int id);
    test_id = id;
    drive_inputs(1'b1, 1'b0, 0, 1'b0);
  endtask

  task automatic wait_for_done();
    @(negedge hwclk);
    while (!done) @(negedge hwclk);
    while (busy) @(negedge hwclk);
  endtask

  task automatic finish_stream();
    drive_inputs(1'b0, 1'b0, 0, 1'b1);
    drive_inputs(1'b0, 1'b0, 0, 1'b0);
    wait_for_done();
  endtask

  initial begin
    int n, gap, s, fa, fb, fn;
    lfsr_q    = 16'd14425;
    rst_n     = 1'b0;
    start     = 1'b0;
    sym_valid = 1'b0;
    sym       = '0;
    eof       = 1'b0;
    test_id   = 0;
    repeat (16) @(posedge hwclk);
    @(negedge hwclk);
    rst_n = 1'b1;

    start_build(0);
    repeat (20) send_symbol(9);
    finish_stream();

    start_build(1);
    repeat (3) begin
      for (int k = 0; k < `T05_NSYM; k++) begin
        send_symbol(k);
      end
    end
    finish_stream();

    // Fibonacci counts chain every symbol, depth 15 within the stream limit
    start_build(2);
    fa = 1;
    fb = 1;
    for (int k = 0; k < `T05_NSYM; k++) begin
      repeat (fa) send_symbol(k);
      fn = fa + fb;
      fa = fb;
      fb = fn;
    end
    finish_stream();

    repeat (6) begin
      start_build(3);
      take_bits(8, n);
      repeat (n + 1) begin
        take_bits(1, gap);
        if (gap != 0) begin
          drive_inputs(1'b0, 1'b0, 0, 1'b0);
        end
        take_bits(SYMW, s);
        send_symbol(s);
      end
      finish_stream();
    end

    // Empty stream, then a start pulse while the build runs
    start_build(4);
    drive_inputs(1'b0, 1'b0, 0, 1'b1);
    repeat (4) drive_inputs(1'b0, 1'b0, 0, 1'b0);
    drive_inputs(1'b1, 1'b0, 0, 1'b0);
    drive_inputs(1'b0, 1'b0, 0, 1'b0);
    wait_for_done();

    start_build(5);
    for (int k = 0; k < 8; k++) begin
      send_symbol(k % 4);
    end
    finish_stream();
    start_build(5);
    send_symbol(12);
    send_symbol(13);
    send_symbol(13);
    finish_stream();

    repeat (4) @(negedge hwclk);
    $display("Summary: %0d of %0d runs finished, %0d errors", runs, NUM_RUNS, errors);
    if (errors == 0 && runs == NUM_RUNS) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (16 + NUM_RUNS * RUN_CYCLES));
    $display("Timeout: the runs did not finish within %0d cycles",
             16 + NUM_RUNS * RUN_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* t05_huffman_checker.sv */
`default_nettype none

`include "t05_huffman_macros.svh"

module t05_huffman_checker (
  input  wire                          hwclk,
  input  wire                          rst_n_i,
  input  wire [31:0]                   test_id_i,
  input  wire                          start_i,
  input  wire                          sym_valid_i,
  input  wire [$clog2(`T05_NSYM)-1:0]  sym_i,
  input  wire                          eof_i,
  input  wire                          len_valid_i,
  input  wire [$clog2(`T05_NSYM)-1:0]  len_sym_i,
  input  wire t05_huffman_pkg::code_len_t len_i,
  input  wire                          done_i,
  input  wire                          busy_i,
  output int                           runs_o,
  output int                           errors_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned                hist [`T05_NSYM];
  t05_huffman_pkg::code_len_t ref_len [`T05_NSYM];
  logic                       in_run, counting, have_ref, want_done;
  int                         next_sym, run_errs;

  function automatic string test_name(input int id);
    case (id)
      0:       return "single_symbol";
      1:       return "uniform_counts";
      2:       return "max_depth";
      3:       return "random_stream";
      4:       return "empty_stream";
      5:       return "two_runs";
      default: return "unknown";
    endcase
  endfunction

  // Pairs the two lightest live nodes, equal weights go to the lower index
  function automatic void build_ref_lengths();
    int unsigned                wgt [`T05_NNODE];
    bit                         alive [`T05_NNODE];
    bit                         has_par [`T05_NNODE];
    t05_huffman_pkg::node_idx_t parent [`T05_NNODE];
    int                         live, nodes, a, b, n, depth;
    live  = 0;
    nodes = `T05_NSYM;
    for (int i = 0; i < `T05_NNODE; i++) begin
      wgt[i]     = 0;
      alive[i]   = 1'b0;
      has_par[i] = 1'b0;
      parent[i]  = '0;
    end
    for (int s = 0; s < `T05_NSYM; s++) begin
      wgt[s]   = hist[s];
      alive[s] = (hist[s] != 0);
      if (alive[s]) begin
        live++;
      end
    end
    for (int step = 0; step < `T05_NSYM - 1; step++) begin
      a = -1;
      b = -1;
      for (int i = 0; i < nodes; i++) begin
        if (alive[i] && (a < 0 || wgt[i] < wgt[a])) begin
          a = i;
        end
      end
      for (int i = 0; i < nodes; i++) begin
        if (alive[i] && i != a && (b < 0 || wgt[i] < wgt[b])) begin
          b = i;
        end
      end
      if (b >= 0) begin
        wgt[nodes]   = wgt[a] + wgt[b];
        alive[nodes] = 1'b1;
        alive[a]     = 1'b0;
        alive[b]     = 1'b0;
        parent[a]    = t05_huffman_pkg::node_idx_t'(nodes);
        parent[b]    = t05_huffman_pkg::node_idx_t'(nodes);
        has_par[a]   = 1'b1;
        has_par[b]   = 1'b1;
        nodes++;
      end
    end
    // Depth is the number of parent hops up to the root
    for (int s = 0; s < `T05_NSYM; s++) begin
      depth = 0;
      n     = s;
      while (has_par[n]) begin
        n = int'(parent[n]);
        depth++;
      end
      if (hist[s] == 0) begin
        depth = 0;
      end else if (live == 1) begin
        depth = 1;
      end
      ref_len[s] = t05_huffman_pkg::code_len_t'(depth);
    end
  endfunction

  task automatic count_error();
    errors_o++;
    run_errs++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", test_name(test_id_i), msg);
    count_error();
  endtask

  task automatic close_run();
    runs_o++;
    if (run_errs == 0) begin
      $display("[run %0d] %s: ok", runs_o, test_name(test_id_i));
    end else begin
      $display("[run %0d] %s: %0d error(s)", runs_o, test_name(test_id_i), run_errs);
    end
    in_run    = 1'b0;
    have_ref  = 1'b0;
    want_done = 1'b0;
  endtask

  initial begin
    runs_o    = 0;
    errors_o  = 0;
    in_run    = 1'b0;
    counting  = 1'b0;
    have_ref  = 1'b0;
    want_done = 1'b0;
    next_sym  = 0;
    run_errs  = 0;
  end

  always @(posedge hwclk) begin
    if (rst_n_i) begin
      // Busy spans the cycle after start through the done cycle
      if (in_run && !busy_i) begin
        report_error("busy_o dropped while a build was running");
      end else if (!in_run && busy_i) begin
        report_error("busy_o high while no build was running");
      end

      // Outputs seen here were set during the cycle before this edge
      if (in_run) begin
        if (want_done) begin
          if (!done_i) begin
            report_error("done_o did not follow the sixteenth length pulse");
          end
          close_run();
        end else if (done_i) begin
          report_error($sformatf("done_o arrived after %0d of 16 lengths", next_sym));
          close_run();
        end else if (len_valid_i) begin
          if (!have_ref) begin
            report_error("length pulse arrived before eof");
          end else if (int'(len_sym_i) != next_sym) begin
            report_error($sformatf("symbol %0d arrived where symbol %0d was due",
                                   len_sym_i, next_sym));
          end else if (len_i !== ref_len[next_sym]) begin
            $display("MISMATCH %s symbol %0d: expected %0d, actual %0d",
                     test_name(test_id_i), next_sym, ref_len[next_sym], len_i);
            count_error();
          end
          next_sym++;
          want_done = (next_sym == `T05_NSYM);
        end
      end else if (len_valid_i || done_i) begin
        report_error("output pulse while no build was running");
      end

      // The DUT takes start only when idle
      if (!in_run && start_i) begin
        in_run    = 1'b1;
        counting  = 1'b1;
        have_ref  = 1'b0;
        want_done = 1'b0;
        next_sym  = 0;
        run_errs  = 0;
        for (int s = 0; s < `T05_NSYM; s++) begin
          hist[s] = 0;
        end
      end else if (counting) begin
        if (sym_valid_i) begin
          hist[sym_i]++;
        end
        if (eof_i) begin
          counting = 1'b0;
          build_ref_lengths();
          have_ref = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* t05_huffman_top.sv */
`default_nettype none

`include "t05_huffman_macros.svh"

module t05_huffman_top (
  input  wire                          hwclk,
  input  wire                          rst_n_i,
  input  wire                          start_i,
  input  wire                          sym_valid_i,
  input  wire [$clog2(`T05_NSYM)-1:0]  sym_i,
  input  wire                          eof_i,
  output logic                         len_valid_o,
  output logic [$clog2(`T05_NSYM)-1:0] len_sym_o,
  output t05_huffman_pkg::code_len_t   len_o,
  output logic                         done_o,
  output logic                         busy_o
);

  logic                       clear, inc, merge, scan_start, walk_start, len_done;
  logic                       scan_active, scan_last, found2, walk_is_root, walk_alive;
  t05_huffman_pkg::node_idx_t inc_sym, scan_idx, least1, least2, walk_sym, walk_idx, walk_par;
  t05_huffman_pkg::weight_t   sum_wgt;
  t05_huffman_pkg::node_rec_t scan_rec;
  logic [`T05_IDXW-1:0]       live_sym_cnt;

  t05_controller controller_inst (
    .hwclk(hwclk), .rst_n_i(rst_n_i), .start_i(start_i), .sym_valid_i(sym_valid_i),
    .sym_i(sym_i), .eof_i(eof_i), .found2_i(found2), .scan_last_i(scan_last),
    .len_done_i(len_done), .clear_o(clear), .inc_o(inc), .inc_sym_o(inc_sym),
    .scan_start_o(scan_start), .merge_o(merge), .walk_start_o(walk_start),
    .walk_sym_o(walk_sym), .len_valid_o(len_valid_o), .len_sym_o(len_sym_o),
    .done_o(done_o), .busy_o(busy_o)
  );

  t05_node_table node_table_inst (
    .hwclk(hwclk), .rst_n_i(rst_n_i), .clear_i(clear), .inc_i(inc), .inc_sym_i(inc_sym),
    .merge_i(merge), .least1_i(least1), .least2_i(least2), .sum_i(sum_wgt),
    .scan_idx_i(scan_idx), .scan_rec_o(scan_rec), .walk_idx_i(walk_idx),
    .walk_parent_o(walk_par), .walk_is_root_o(walk_is_root), .walk_alive_o(walk_alive),
    .live_sym_cnt_o(live_sym_cnt)
  );

  t05_scan_counter scan_counter_inst (
    .hwclk(hwclk), .rst_n_i(rst_n_i), .start_i(scan_start), .idx_o(scan_idx),
    .active_o(scan_active), .last_o(scan_last)
  );

  t05_find_least find_least_inst (
    .hwclk(hwclk), .rst_n_i(rst_n_i), .start_i(scan_start), .valid_i(scan_active),
    .idx_i(scan_idx), .rec_i(scan_rec), .least1_o(least1), .least2_o(least2),
    .sum_o(sum_wgt), .found2_o(found2)
  );

  t05_code_length code_length_inst (
    .hwclk(hwclk), .rst_n_i(rst_n_i), .start_i(walk_start), .sym_i(walk_sym),
    .live_sym_cnt_i(live_sym_cnt), .parent_i(walk_par), .is_root_i(walk_is_root),
    .alive_leaf_i(walk_alive), .walk_idx_o(walk_idx), .len_o(len_o), .done_o(len_done)
  );

endmodule

`default_nettype wire

/* t05_code_length.sv */
`default_nettype none

`include "t05_huffman_macros.svh"

module t05_code_length (
  input  wire                             hwclk,
  input  wire                             rst_n_i,
  input  wire                             start_i,
  input  wire t05_huffman_pkg::node_idx_t sym_i,
  input  wire [`T05_IDXW-1:0]             live_sym_cnt_i,
  input  wire t05_huffman_pkg::node_idx_t parent_i,
  input  wire                             is_root_i,
  input  wire                             alive_leaf_i,
  output t05_huffman_pkg::node_idx_t      walk_idx_o,
  output t05_huffman_pkg::code_len_t      len_o,
  output logic                            done_o
);

  logic                       run_q;
  logic                       first_q;
  t05_huffman_pkg::code_len_t hops_q;

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q      <= 1'b0;
      first_q    <= 1'b0;
      hops_q     <= '0;
      walk_idx_o <= '0;
      len_o      <= '0;
      done_o     <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        run_q      <= 1'b1;
        first_q    <= 1'b1;
        hops_q     <= '0;
        walk_idx_o <= sym_i;
      end else if (run_q && first_q) begin
        first_q <= 1'b0;
        if (!alive_leaf_i || live_sym_cnt_i == 1) begin
          // Unused symbol or a one-symbol tree ends at the leaf
          len_o  <= alive_leaf_i ? t05_huffman_pkg::code_len_t'(1) : '0;
          done_o <= 1'b1;
          run_q  <= 1'b0;
        end else begin
          walk_idx_o <= parent_i;
          hops_q     <= t05_huffman_pkg::code_len_t'(1);
        end
      end else if (run_q) begin
        if (is_root_i) begin
          len_o  <= hops_q;
          done_o <= 1'b1;
          run_q  <= 1'b0;
        end else begin
          walk_idx_o <= parent_i;
          hops_q     <= hops_q + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* t05_find_least.sv */
`default_nettype none

module t05_find_least (
  input  wire                             hwclk,
  input  wire                             rst_n_i,
  input  wire                             start_i,
  input  wire                             valid_i,
  input  wire t05_huffman_pkg::node_idx_t idx_i,
  input  wire t05_huffman_pkg::node_rec_t rec_i,
  output t05_huffman_pkg::node_idx_t      least1_o,
  output t05_huffman_pkg::node_idx_t      least2_o,
  output t05_huffman_pkg::weight_t        sum_o,
  output logic                            found2_o
);

  t05_huffman_pkg::weight_t wgt1_q, wgt2_q;
  logic                     have1_q;
  logic                     take1, take2;

  // Strict compare keeps the earlier, lower index on a tie
  assign take1 = valid_i && rec_i.alive && (!have1_q || rec_i.weight < wgt1_q);
  assign take2 = valid_i && rec_i.alive && !take1 && (!found2_o || rec_i.weight < wgt2_q);

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      have1_q  <= 1'b0;
      found2_o <= 1'b0;
    end else if (start_i) begin
      have1_q  <= 1'b0;
      found2_o <= 1'b0;
    end else if (take1) begin
      have1_q  <= 1'b1;
      found2_o <= have1_q;
    end else if (take2) begin
      found2_o <= 1'b1;
    end
  end

  always_ff @(posedge hwclk) begin
    if (take1) begin
      // Old lightest slides down to second place
      least2_o <= least1_o;
      wgt2_q   <= wgt1_q;
      least1_o <= idx_i;
      wgt1_q   <= rec_i.weight;
    end else if (take2) begin
      least2_o <= idx_i;
      wgt2_q   <= rec_i.weight;
    end
  end

  assign sum_o = wgt1_q + wgt2_q;

endmodule

`default_nettype wire

/* t05_controller.sv */
`default_nettype none

`include "t05_huffman_macros.svh"

module t05_controller (
  input  wire                         hwclk,
  input  wire                         rst_n_i,
  input  wire                         start_i,
  input  wire                         sym_valid_i,
  input  wire [$clog2(`T05_NSYM)-1:0] sym_i,
  input  wire                         eof_i,
  input  wire                         found2_i,
  input  wire                         scan_last_i,
  input  wire                         len_done_i,
  output logic                        clear_o,
  output logic                        inc_o,
  output t05_huffman_pkg::node_idx_t  inc_sym_o,
  output logic                        scan_start_o,
  output logic                        merge_o,
  output logic                        walk_start_o,
  output t05_huffman_pkg::node_idx_t  walk_sym_o,
  output logic                        len_valid_o,
  output logic [$clog2(`T05_NSYM)-1:0] len_sym_o,
  output logic                        done_o,
  output logic                        busy_o
);

  t05_huffman_pkg::ctrl_state_t     state_q, state_d;
  logic [$clog2(`T05_NSYM)-1:0]     walk_sym_q;
  logic                             walk_start_q;
  logic                             last_sym;

  assign last_sym = (walk_sym_q == $clog2(`T05_NSYM)'(`T05_NSYM - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      t05_huffman_pkg::IDLE:  if (start_i) state_d = t05_huffman_pkg::COUNT;
      t05_huffman_pkg::COUNT: if (eof_i) state_d = t05_huffman_pkg::SCAN;
      t05_huffman_pkg::SCAN:  if (scan_last_i) state_d = t05_huffman_pkg::MERGE;
      // Scan results are valid here, either merge and rescan or walk
      t05_huffman_pkg::MERGE: begin
        state_d = found2_i ? t05_huffman_pkg::SCAN : t05_huffman_pkg::WALK;
      end
      t05_huffman_pkg::WALK:  if (len_done_i) state_d = t05_huffman_pkg::EMIT;
      t05_huffman_pkg::EMIT:  begin
        state_d = last_sym ? t05_huffman_pkg::DONE : t05_huffman_pkg::WALK;
      end
      t05_huffman_pkg::DONE:  state_d = t05_huffman_pkg::IDLE;
      default:                state_d = t05_huffman_pkg::IDLE;
    endcase
  end

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= t05_huffman_pkg::IDLE;
      walk_sym_q   <= '0;
      walk_start_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      walk_start_q <= 1'b0;
      if (state_q == t05_huffman_pkg::MERGE && !found2_i) begin
        walk_sym_q   <= '0;
        walk_start_q <= 1'b1;
      end else if (state_q == t05_huffman_pkg::EMIT && !last_sym) begin
        walk_sym_q   <= walk_sym_q + 1'b1;
        walk_start_q <= 1'b1;
      end
    end
  end

  assign clear_o      = (state_q == t05_huffman_pkg::IDLE) && start_i;
  assign inc_o        = (state_q == t05_huffman_pkg::COUNT) && sym_valid_i;
  assign inc_sym_o    = t05_huffman_pkg::node_idx_t'(sym_i);
  // First scan on eof, then one after every merge
  assign scan_start_o = ((state_q == t05_huffman_pkg::COUNT) && eof_i) ||
                        ((state_q == t05_huffman_pkg::MERGE) && found2_i);
  assign merge_o      = (state_q == t05_huffman_pkg::MERGE) && found2_i;
  assign walk_start_o = walk_start_q;
  assign walk_sym_o   = t05_huffman_pkg::node_idx_t'(walk_sym_q);
  assign len_valid_o  = (state_q == t05_huffman_pkg::EMIT);
  assign len_sym_o    = walk_sym_q;
  assign done_o       = (state_q == t05_huffman_pkg::DONE);
  assign busy_o       = (state_q != t05_huffman_pkg::IDLE);

endmodule

`default_nettype wire

/* t05_scan_counter.sv */
`default_nettype none

`include "t05_huffman_macros.svh"

module t05_scan_counter (
  input  wire                        hwclk,
  input  wire                        rst_n_i,
  input  wire                        start_i,
  output t05_huffman_pkg::node_idx_t idx_o,
  output logic                       active_o,
  output logic                       last_o
);

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_o    <= '0;
      active_o <= 1'b0;
    end else if (start_i) begin
      idx_o    <= '0;
      active_o <= 1'b1;
    end else if (active_o) begin
      // Stop after the highest node index
      if (last_o) begin
        active_o <= 1'b0;
        idx_o    <= '0;
      end else begin
        idx_o <= idx_o + 1'b1;
      end
    end
  end

  assign last_o = active_o && (idx_o == t05_huffman_pkg::node_idx_t'(`T05_NNODE - 1));

endmodule

`default_nettype wire

/* t05_node_table.sv */
`default_nettype none

`include "t05_huffman_macros.svh"

module t05_node_table (
  input  wire                             hwclk,
  input  wire                             rst_n_i,
  input  wire                             clear_i,
  input  wire                             inc_i,
  input  wire t05_huffman_pkg::node_idx_t inc_sym_i,
  input  wire                             merge_i,
  input  wire t05_huffman_pkg::node_idx_t least1_i,
  input  wire t05_huffman_pkg::node_idx_t least2_i,
  input  wire t05_huffman_pkg::weight_t   sum_i,
  input  wire t05_huffman_pkg::node_idx_t scan_idx_i,
  output t05_huffman_pkg::node_rec_t      scan_rec_o,
  input  wire t05_huffman_pkg::node_idx_t walk_idx_i,
  output t05_huffman_pkg::node_idx_t      walk_parent_o,
  output logic                            walk_is_root_o,
  output logic                            walk_alive_o,
  output logic [`T05_IDXW-1:0]            live_sym_cnt_o
);

  // used_q marks entries written since clear, dead_q marks merged nodes
  logic [`T05_NNODE-1:0]      used_q;
  logic [`T05_NNODE-1:0]      dead_q;
  t05_huffman_pkg::node_idx_t next_free_q;
  logic                       pend_q;
  t05_huffman_pkg::node_idx_t pend_idx_q;
  t05_huffman_pkg::node_idx_t pend_par_q;

  t05_huffman_pkg::node_rec_t scan_raw, inc_raw, wgt_wdata;
  t05_huffman_pkg::node_idx_t par_raw, par_waddr, par_wdata;
  t05_huffman_pkg::weight_t   inc_old;
  logic                       par_we;

  assign inc_old   = used_q[inc_sym_i] ? inc_raw.weight : '0;
  assign wgt_wdata = merge_i ? {1'b1, sum_i} : {1'b1, inc_old + 1'b1};

  t05_node_ram #(
    .payload_t (t05_huffman_pkg::node_rec_t)
  ) wgt_ram_inst (
    .hwclk    (hwclk),
    .rst_n_i  (rst_n_i),
    .we_i     ((inc_i | merge_i) & ~clear_i),
    .waddr_i  (merge_i ? next_free_q : inc_sym_i),
    .wdata_i  (wgt_wdata),
    .raddr_i  (scan_idx_i),
    .rdata_o  (scan_raw),
    .raddr2_i (inc_sym_i),
    .rdata2_o (inc_raw)
  );

  // Second parent write of a merge lands one cycle later
  assign par_we    = (merge_i | pend_q) & ~clear_i;
  assign par_waddr = merge_i ? least1_i : pend_idx_q;
  assign par_wdata = merge_i ? next_free_q : pend_par_q;

  t05_node_ram #(
    .payload_t (t05_huffman_pkg::node_idx_t)
  ) par_ram_inst (
    .hwclk    (hwclk),
    .rst_n_i  (rst_n_i),
    .we_i     (par_we),
    .waddr_i  (par_waddr),
    .wdata_i  (par_wdata),
    .raddr_i  (walk_idx_i),
    .rdata_o  (par_raw),
    .raddr2_i (scan_idx_i),
    .rdata2_o ()
  );

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      used_q         <= '0;
      dead_q         <= '0;
      next_free_q    <= t05_huffman_pkg::node_idx_t'(`T05_NSYM);
      pend_q         <= 1'b0;
      pend_idx_q     <= '0;
      pend_par_q     <= '0;
      live_sym_cnt_o <= '0;
    end else if (clear_i) begin
      used_q         <= '0;
      dead_q         <= '0;
      next_free_q    <= t05_huffman_pkg::node_idx_t'(`T05_NSYM);
      pend_q         <= 1'b0;
      live_sym_cnt_o <= '0;
    end else begin
      pend_q <= merge_i;
      if (inc_i) begin
        used_q[inc_sym_i] <= 1'b1;
        if (!used_q[inc_sym_i]) begin
          live_sym_cnt_o <= live_sym_cnt_o + 1'b1;
        end
      end
      if (merge_i) begin
        used_q[next_free_q] <= 1'b1;
        dead_q[least1_i]    <= 1'b1;
        dead_q[least2_i]    <= 1'b1;
        pend_idx_q          <= least2_i;
        pend_par_q          <= next_free_q;
        next_free_q         <= next_free_q + 1'b1;
      end
    end
  end

  assign scan_rec_o.alive  = scan_raw.alive & used_q[scan_idx_i] & ~dead_q[scan_idx_i];
  assign scan_rec_o.weight = used_q[scan_idx_i] ? scan_raw.weight : '0;

  // Only merged nodes own a parent, so a stale entry reads as zero
  assign walk_parent_o  = dead_q[walk_idx_i] ? par_raw : '0;
  assign walk_alive_o   = used_q[walk_idx_i];
  assign walk_is_root_o = (walk_parent_o == '0) &&
                          !(walk_idx_i < `T05_NSYM && walk_alive_o && live_sym_cnt_o == 1);

endmodule

`default_nettype wire

/* t05_node_ram.sv */
`default_nettype none

`include "t05_huffman_macros.svh"

module t05_node_ram #(
  parameter type payload_t = logic
) (
  input  wire                        hwclk,
  input  wire                        rst_n_i,
  input  wire                        we_i,
  input  wire t05_huffman_pkg::node_idx_t waddr_i,
  input  wire payload_t              wdata_i,
  input  wire t05_huffman_pkg::node_idx_t raddr_i,
  output payload_t                   rdata_o,
  input  wire t05_huffman_pkg::node_idx_t raddr2_i,
  output payload_t                   rdata2_o
);

  payload_t mem [`T05_NNODE];

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `T05_NNODE; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Both read ports are combinational
  assign rdata_o  = mem[raddr_i];
  assign rdata2_o = mem[raddr2_i];

endmodule

`default_nettype wire

/* t05_huffman_pkg.sv */
`default_nettype none

`include "t05_huffman_macros.svh"

package t05_huffman_pkg;

  typedef logic [`T05_IDXW-1:0] node_idx_t;

  typedef logic [`T05_WGTW-1:0] weight_t;

  // Payload of the weight memory
  typedef struct packed {
    logic    alive;
    weight_t weight;
  } node_rec_t;

  typedef logic [`T05_LENW-1:0] code_len_t;

  // Controller phases
  typedef enum logic [2:0] {
    IDLE,
    COUNT,
    SCAN,
    MERGE,
    WALK,
    EMIT,
    DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

/* t05_huffman_macros.svh */
`ifndef T05_HUFFMAN_MACROS_SVH
`define T05_HUFFMAN_MACROS_SVH

// Alphabet size, one leaf per 4-bit symbol
`define T05_NSYM 16

// Leaves plus internal nodes of a full binary tree
`define T05_NNODE 31

// Node index width
`define T05_IDXW 5

// Weight and count width
`define T05_WGTW 16

// Code length width, deep enough for a depth of 15
`define T05_LENW 4

// Longest legal stream so that node sums stay in range
`define T05_MAXCHARS 4095

`endif
